/* trace_capture_top.f */
verilog/trace_cfg_pkg.sv
verilog/capture_fmt_pkg.sv
verilog/trace_pattern_matcher.sv
verilog/capture_fsm.sv
verilog/capture_timer.sv
verilog/record_packer.sv
verilog/trace_capture_top.sv
tb/trace_capture_assertions.sv
tb/trace_capture_tb.sv

/* Bender.yml */
package:
  name: trace_capture

sources:
  - verilog/trace_cfg_pkg.sv
  - verilog/capture_fmt_pkg.sv
  - verilog/trace_pattern_matcher.sv
  - verilog/capture_fsm.sv
  - verilog/capture_timer.sv
  - verilog/record_packer.sv
  - verilog/trace_capture_top.sv
  - target: test
    files:
      - tb/trace_capture_assertions.sv
      - tb/trace_capture_tb.sv

/* tb/trace_capture_tb.sv */
// ==========================================================================
// Directed testbench for the fe_clk trace capture front end.
// Inputs change 1 ns after the rising edge; outputs are sampled there too.
// A window model predicts match counts and record rule vectors.
// Record tests use idle byte 00 and full-mask patterns so idle never matches.
// ==========================================================================

`default_nettype none

module trace_capture_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import trace_cfg_pkg::*;
  import capture_fmt_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RAND_LEN     = 1000;
  localparam int LONG_GAP     = 5000;
  localparam int TOTAL_CYCLES = RAND_LEN + (RAND_LEN / 40) * 4 + LONG_GAP + 400;
  localparam logic [31:0] TRIG_WORD  = 32'h1122_3344;
  localparam logic [31:0] MATCH_WORD = 32'h5566_7788;

  logic          fe_clk;
  logic          reset;
  trace_byte_t   trace_data;
  rule_words_t   pattern;
  rule_words_t   mask;
  rule_vec_t     rule_enable;
  rule_vec_t     trig_enable;
  cap_len_t      capture_len;
  logic          arm;
  logic          fifo_full;
  record_word_t  fifo_data;
  logic          fifo_wr;
  logic          trig_out;
  logic          capturing;
  logic          capture_done;
  logic          overflow;
  match_counts_t match_counts;

  window_t       win_model;              // window as the DUT holds it
  match_count_t  cnt_model [NUM_RULES];
  logic [31:0]   lfsr;
  int            wr_seen;
  int            trig_seen;

  trace_capture_top dut (.*);

  bind trace_capture_top trace_capture_assertions u_assertions (.*);

  initial begin
    fe_clk = 1'b0;
    forever #(CLK_PERIOD / 2) fe_clk = ~fe_clk;
  end

  // a rule hits when enabled and no mask-1 bit differs from its pattern
  function automatic rule_vec_t rule_hits(input window_t w);
    rule_vec_t h;
    h = '0;
    for (int r = 0; r < NUM_RULES; r++) begin
      h[r] = rule_enable[r];
      for (int b = 0; b < 8 * WINDOW_BYTES; b++) begin
        if (mask[r][b] && (w[b] != pattern[r][b]))
          h[r] = 1'b0;
      end
    end
    return h;
  endfunction

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic trace_byte_t rand_byte();
    trace_byte_t b;
    for (int i = 0; i < 8; i++) begin
      b    = {b[6:0], lfsr[0]};   // one step per bit
      lfsr = lfsr_step(lfsr);
    end
    return b;
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // models one fe_clk edge and then drives the next byte
  task automatic tick(input trace_byte_t b, input logic a);
    rule_vec_t h;
    @(posedge fe_clk);
    h = rule_hits(win_model);
    for (int r = 0; r < NUM_RULES; r++) begin
      if (reset || arm)
        cnt_model[r] = '0;
      else if (h[r] && (cnt_model[r] != 8'hFF))
        cnt_model[r] = cnt_model[r] + 1'b1;
    end
    win_model = reset ? '0 : {win_model[23:0], trace_data};
    #1;
    trace_data = b;
    arm        = a;
    for (int r = 0; r < NUM_RULES; r++) begin
      check($sformatf("match_counts[%0d]", r), match_counts[r], cnt_model[r]);
    end
    if (fifo_wr) wr_seen++;
    if (trig_out) trig_seen++;
  endtask

  task automatic send_bytes(input logic [31:0] word);
    for (int i = 3; i >= 0; i--) begin
      tick(word[8*i +: 8], 1'b0);   // oldest byte first
    end
  endtask

  // gap is the cycle count since the previous planted word and is at least 8
  task automatic send_record(input logic [31:0] word, input int gap, input logic is_trig,
                             input logic exp_wr, input logic exp_done);
    record_word_t exp;
    exp.cmd   = is_trig ? CMD_TRIGGER : CMD_MATCH;
    exp.rules = rule_hits(word);
    exp.ts    = is_trig ? '0 : ((gap > int'(TS_MAX)) ? TS_MAX : timestamp_t'(gap));
    repeat (gap - 7) tick(8'h00, 1'b0);
    send_bytes(word);
    tick(8'h00, 1'b0);
    tick(8'h00, 1'b0);
    check("fifo_wr before latency", fifo_wr, 1'b0);
    tick(8'h00, 1'b0);                // third edge after the last byte is sampled
    check("fifo_wr", fifo_wr, exp_wr);
    check("capture_done", capture_done, exp_done);
    check("trig_out", trig_out, is_trig);
    if (exp_wr) check("fifo_data", fifo_data, exp);
  endtask

  task automatic reset_dut(input rule_vec_t en, input rule_vec_t trig, input cap_len_t len);
    rule_enable = en;
    trig_enable = trig;
    capture_len = len;
    reset       = 1'b1;
    repeat (8) tick(8'h00, 1'b0);
    reset       = 1'b0;
  endtask

  task automatic test_match_counts();
    reset_dut(4'b1111, 4'b0000, 8'd1);
    for (int n = 0; n < RAND_LEN; n++) begin
      if (n % 40 == 0) send_bytes((n % 80 == 0) ? TRIG_WORD : 32'h5A12_34C3);
      tick(rand_byte(), 1'b0);
    end
    check("rule 3 saturated", match_counts[3], 8'hFF);
    tick(rand_byte(), 1'b1);
    tick(rand_byte(), 1'b0);
    check("counts after arm", match_counts, '0);
  endtask

  task automatic test_not_armed();
    int wr0;
    int tr0;
    reset_dut(4'b0011, 4'b0001, 8'd4);
    wr0 = wr_seen;
    tr0 = trig_seen;
    send_bytes(TRIG_WORD);
    send_bytes(MATCH_WORD);
    repeat (4) tick(8'h00, 1'b0);
    check("writes while idle", wr_seen, wr0);
    check("triggers while idle", trig_seen, tr0);
    check("rule 0 count", match_counts[0], 8'd1);
    check("rule 1 count", match_counts[1], 8'd1);
  endtask

  task automatic test_trigger();
    reset_dut(4'b0011, 4'b0001, 8'd10);
    tick(8'h00, 1'b1);
    send_record(TRIG_WORD, 8, 1'b1, 1'b1, 1'b0);
    check("capturing after trigger", capturing, 1'b1);
  endtask

  task automatic test_timestamps();
    reset_dut(4'b0011, 4'b0001, 8'd10);
    tick(8'h00, 1'b1);
    send_record(TRIG_WORD, 8, 1'b1, 1'b1, 1'b0);
    send_record(MATCH_WORD, 10, 1'b0, 1'b1, 1'b0);
    send_record(MATCH_WORD, 37, 1'b0, 1'b1, 1'b0);
    send_record(MATCH_WORD, LONG_GAP, 1'b0, 1'b1, 1'b0);   // saturates
  endtask

  task automatic test_capture_len();
    int wr0;
    reset_dut(4'b0011, 4'b0001, 8'd3);
    tick(8'h00, 1'b1);
    send_record(TRIG_WORD, 8, 1'b1, 1'b1, 1'b0);
    send_record(MATCH_WORD, 9, 1'b0, 1'b1, 1'b0);
    send_record(MATCH_WORD, 12, 1'b0, 1'b1, 1'b1);
    check("capturing after last record", capturing, 1'b0);
    wr0 = wr_seen;
    send_bytes(MATCH_WORD);
    repeat (4) tick(8'h00, 1'b0);
    check("writes after capture", wr_seen, wr0);
    tick(8'h00, 1'b1);                // rearm
    send_record(TRIG_WORD, 8, 1'b1, 1'b1, 1'b0);
  endtask

  task automatic test_fifo_full();
    reset_dut(4'b0011, 4'b0001, 8'd3);
    tick(8'h00, 1'b1);
    send_record(TRIG_WORD, 8, 1'b1, 1'b1, 1'b0);
    fifo_full = 1'b1;
    send_record(MATCH_WORD, 9, 1'b0, 1'b0, 1'b0);   // dropped
    check("overflow after drop", overflow, 1'b1);
    fifo_full = 1'b0;
    send_record(MATCH_WORD, 11, 1'b0, 1'b1, 1'b1);
    tick(8'h00, 1'b1);
    tick(8'h00, 1'b0);
    check("overflow after arm", overflow, 1'b0);
  endtask

  initial begin
    reset       = 1'b1;
    trace_data  = '0;
    arm         = 1'b0;
    fifo_full   = 1'b0;
    rule_enable = '0;
    trig_enable = '0;
    capture_len = '0;
    pattern[0]  = TRIG_WORD;
    mask[0]     = '1;
    pattern[1]  = MATCH_WORD;
    mask[1]     = '1;
    pattern[2]  = 32'h5A00_00C3;      // oldest and newest byte only
    mask[2]     = 32'hFF00_00FF;
    pattern[3]  = '0;                 // any even newest byte
    mask[3]     = 32'h0000_0001;
    win_model   = '0;
    lfsr        = 32'hb699_b544;
    wr_seen     = 0;
    trig_seen   = 0;
    for (int r = 0; r < NUM_RULES; r++) cnt_model[r] = '0;
    test_match_counts();
    test_not_armed();
    test_trigger();
    test_timestamps();
    test_capture_len();
    test_fifo_full();
    $display("ALL TESTS PASSED");
    $finish;
  end

  // stops at the first failing bound assertion
  initial begin
    wait (dut.u_assertions.fail_count != 0);
    $display("a protocol assertion on the DUT failed at %0d ns", $time);
    $display("SOME TESTS FAILED");
    $fatal(1, "protocol assertion failed");
  end

  initial begin
    #(2 * TOTAL_CYCLES * CLK_PERIOD);
    $display("timeout: tests did not finish within %0d cycles", 2 * TOTAL_CYCLES);
    $display("SOME TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* tb/trace_capture_assertions.sv */
// ==========================================================================
// Protocol checks on the capture top level, bound into trace_capture_top.
// All checks are off while reset is high.
// ==========================================================================

`default_nettype none

module trace_capture_assertions (
  input wire fe_clk,
  input wire reset,
  input wire fifo_full,
  input wire fifo_wr,
  input wire trig_out,
  input wire capturing,
  input wire capture_done
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0;   // failed checks so far

  // a full cycle drops its record, so no write follows it
  a_no_wr_after_full: assert property (@(posedge fe_clk) disable iff (reset)
    fifo_full |=> !fifo_wr)
    else begin
      $error("fifo_wr asserted after a fifo_full cycle");
      fail_count++;
    end

  a_trig_one_cycle: assert property (@(posedge fe_clk) disable iff (reset)
    trig_out |=> !trig_out)
    else begin
      $error("trig_out held for more than one cycle");
      fail_count++;
    end

  a_wr_in_capture: assert property (@(posedge fe_clk) disable iff (reset)
    fifo_wr |-> (capturing || capture_done))
    else begin
      $error("fifo_wr outside a capture");
      fail_count++;
    end

endmodule

`default_nettype wire

/* verilog/trace_capture_top.sv */
// ==========================================================================
// fe_clk trace capture front end, one trace byte per cycle.
// Fixed latency of 3 edges from sampling a byte to its FIFO write.
// Configuration inputs are expected to be static during a capture.
// fifo_full drops records, it never stalls the pipeline.
// ==========================================================================

`default_nettype none

module trace_capture_top (
  input  wire                               fe_clk,
  input  wire                               reset,
  input  wire trace_cfg_pkg::trace_byte_t   trace_data,
  input  wire trace_cfg_pkg::rule_words_t   pattern,
  input  wire trace_cfg_pkg::rule_words_t   mask,
  input  wire trace_cfg_pkg::rule_vec_t     rule_enable,
  input  wire trace_cfg_pkg::rule_vec_t     trig_enable,
  input  wire capture_fmt_pkg::cap_len_t    capture_len,
  input  wire                               arm,
  input  wire                               fifo_full,
  output capture_fmt_pkg::record_word_t     fifo_data,
  output logic                              fifo_wr,
  output logic                              trig_out,
  output logic                              capturing,
  output logic                              capture_done,
  output logic                              overflow,
  output trace_cfg_pkg::match_counts_t      match_counts
);

  import trace_cfg_pkg::*;
  import capture_fmt_pkg::*;

  rule_vec_t  match_vec;
  logic       record_due;
  logic       record_is_trigger;
  timestamp_t timestamp;
  logic       last_record;

  trace_pattern_matcher u_matcher (
    .fe_clk       (fe_clk),
    .reset        (reset),
    .trace_data   (trace_data),
    .pattern      (pattern),
    .mask         (mask),
    .rule_enable  (rule_enable),
    .arm          (arm),
    .match_vec    (match_vec),
    .match_counts (match_counts)
  );

  capture_fsm u_fsm (
    .fe_clk            (fe_clk),
    .reset             (reset),
    .arm               (arm),
    .match_vec         (match_vec),
    .trig_enable       (trig_enable),
    .last_record       (last_record),
    .record_due        (record_due),
    .record_is_trigger (record_is_trigger),
    .trig_out          (trig_out),
    .capturing         (capturing),
    .capture_done      (capture_done)
  );

  capture_timer u_timer (
    .fe_clk            (fe_clk),
    .reset             (reset),
    .record_due        (record_due),
    .record_is_trigger (record_is_trigger),
    .capture_len       (capture_len),
    .timestamp         (timestamp),
    .last_record       (last_record)
  );

  record_packer u_packer (
    .fe_clk            (fe_clk),
    .reset             (reset),
    .arm               (arm),
    .record_due        (record_due),
    .record_is_trigger (record_is_trigger),
    .match_vec         (match_vec),
    .timestamp         (timestamp),
    .fifo_full         (fifo_full),
    .fifo_data         (fifo_data),
    .fifo_wr           (fifo_wr),
    .overflow          (overflow)
  );

endmodule

`default_nettype wire

/* verilog/record_packer.sv */
// ==========================================================================
// Builds record words and writes them to the external FIFO.
// No stall: a record due while fifo_full is high is dropped.
// overflow is sticky until the next arm.
// ==========================================================================

`default_nettype none

module record_packer (
  input  wire                               fe_clk,
  input  wire                               reset,
  input  wire                               arm,
  input  wire                               record_due,
  input  wire                               record_is_trigger,
  input  wire trace_cfg_pkg::rule_vec_t     match_vec,
  input  wire capture_fmt_pkg::timestamp_t  timestamp,
  input  wire                               fifo_full,
  output capture_fmt_pkg::record_word_t     fifo_data,
  output logic                              fifo_wr,
  output logic                              overflow
);

  import capture_fmt_pkg::*;

  record_word_t word;

  always_comb begin
    word.rules = match_vec;
    if (record_is_trigger) begin
      word.cmd = CMD_TRIGGER;
      word.ts  = '0;          // trigger marks time zero
    end else begin
      word.cmd = CMD_MATCH;
      word.ts  = timestamp;
    end
  end

  always_ff @(posedge fe_clk) begin
    if (record_due && !fifo_full) begin
      fifo_data <= word;
    end
  end

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      fifo_wr  <= 1'b0;
      overflow <= 1'b0;
    end else begin
      fifo_wr <= record_due && !fifo_full;
      if (record_due && fifo_full) begin
        overflow <= 1'b1;     // a new drop wins over arm
      end else if (arm) begin
        overflow <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/capture_timer.sv */
// ==========================================================================
// Timestamp and record counters for one capture.
// The timestamp is the cycle count since the previous record, up to TS_MAX.
// A record dropped on fifo_full still restarts the time and still counts.
// ==========================================================================

`default_nettype none

module capture_timer (
  input  wire                             fe_clk,
  input  wire                             reset,
  input  wire                             record_due,
  input  wire                             record_is_trigger,
  input  wire capture_fmt_pkg::cap_len_t  capture_len,
  output capture_fmt_pkg::timestamp_t     timestamp,
  output logic                            last_record
);

  import capture_fmt_pkg::*;

  cap_len_t           rec_cnt;    // records so far in this capture
  cap_len_t           len_eff;
  logic [CAP_LEN_W:0] rec_next;   // count including the current record

  assign len_eff  = (capture_len == '0) ? cap_len_t'(1) : capture_len;
  assign rec_next = record_is_trigger ? {{CAP_LEN_W{1'b0}}, 1'b1}
                                      : {1'b0, rec_cnt} + 1'b1;

  assign last_record = (rec_next >= {1'b0, len_eff});

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      timestamp <= '0;
      rec_cnt   <= '0;
    end else begin
      if (record_due) begin
        timestamp <= timestamp_t'(1);   // first cycle after the write
        rec_cnt   <= rec_next[CAP_LEN_W-1:0];
      end else if (timestamp != TS_MAX) begin
        timestamp <= timestamp + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/capture_fsm.sv */
// ==========================================================================
// Arm, trigger and capture control.
// record_due is combinational from the registered match vector.
// arm is only taken in idle; a trigger needs a match on an enabled trigger
// rule. The last record returns to idle and pulses capture_done.
// ==========================================================================

`default_nettype none

module capture_fsm (
  input  wire                             fe_clk,
  input  wire                             reset,
  input  wire                             arm,
  input  wire trace_cfg_pkg::rule_vec_t   match_vec,
  input  wire trace_cfg_pkg::rule_vec_t   trig_enable,
  input  wire                             last_record,
  output logic                            record_due,
  output logic                            record_is_trigger,
  output logic                            trig_out,
  output logic                            capturing,
  output logic                            capture_done
);

  import capture_fmt_pkg::*;

  capture_state_t state;
  capture_state_t state_next;
  logic           trig_hit;    // trigger record this cycle
  logic           match_hit;   // match record this cycle

  assign trig_hit  = (state == ST_ARMED) && (|(match_vec & trig_enable));
  assign match_hit = (state == ST_CAPTURING) && (|match_vec);

  assign record_due        = trig_hit || match_hit;
  assign record_is_trigger = trig_hit;
  assign capturing         = (state == ST_CAPTURING);

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (arm) begin
          state_next = ST_ARMED;
        end
      end
      ST_ARMED: begin
        // capture_len of 1 ends on the trigger record itself
        if (trig_hit) begin
          state_next = last_record ? ST_IDLE : ST_CAPTURING;
        end
      end
      ST_CAPTURING: begin
        if (match_hit && last_record) begin
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      state        <= ST_IDLE;
      trig_out     <= 1'b0;
      capture_done <= 1'b0;
    end else begin
      state        <= state_next;
      trig_out     <= trig_hit;
      capture_done <= record_due && last_record;   // lines up with the last fifo_wr
    end
  end

endmodule

`default_nettype wire

/* verilog/trace_pattern_matcher.sv */
// ==========================================================================
// Byte window and masked pattern compare for all rules.
// match_vec is registered, one cycle after the byte enters the window.
// Counts saturate at all ones and are cleared by arm in any state.
// Mask bits of 0 are don't care; a disabled rule never matches.
// ==========================================================================

`default_nettype none

module trace_pattern_matcher (
  input  wire                               fe_clk,
  input  wire                               reset,
  input  wire trace_cfg_pkg::trace_byte_t   trace_data,
  input  wire trace_cfg_pkg::rule_words_t   pattern,
  input  wire trace_cfg_pkg::rule_words_t   mask,
  input  wire trace_cfg_pkg::rule_vec_t     rule_enable,
  input  wire                               arm,
  output trace_cfg_pkg::rule_vec_t          match_vec,
  output trace_cfg_pkg::match_counts_t      match_counts
);

  import trace_cfg_pkg::*;

  localparam int KEEP_W = 8*(WINDOW_BYTES-1);   // bytes that stay in the window

  window_t   window;
  rule_vec_t hit;      // compare on the current window

  // newest byte in at the bottom, oldest drops off the top
  always_ff @(posedge fe_clk) begin
    if (reset) begin
      window <= '0;
    end else begin
      window <= {window[KEEP_W-1:0], trace_data};
    end
  end

  always_comb begin
    for (int r = 0; r < NUM_RULES; r++) begin
      // only mask-1 bits take part in the compare
      hit[r] = rule_enable[r] && (((window ^ pattern[r]) & mask[r]) == '0);
    end
  end

  always_ff @(posedge fe_clk) begin
    if (reset) begin
      match_vec <= '0;
    end else begin
      match_vec <= hit;
    end
  end

  // counts follow the same compare as match_vec
  always_ff @(posedge fe_clk) begin
    if (reset || arm) begin
      match_counts <= '0;
    end else begin
      for (int r = 0; r < NUM_RULES; r++) begin
        if (hit[r] && (match_counts[r] != '1)) begin
          match_counts[r] <= match_count_t'(match_counts[r] + 1'b1);   // stops at max
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/capture_fmt_pkg.sv */
// ==========================================================================
// Capture record format and controller states.
// A record word is 18 bits: command 17:16, rule vector 15:12, time 11:0.
// Timestamps saturate at TS_MAX and never wrap.
// ==========================================================================

`default_nettype none

package capture_fmt_pkg;

  localparam int TS_W      = 12;
  localparam int CAP_LEN_W = 8;

  typedef logic [TS_W-1:0] timestamp_t;

  localparam timestamp_t TS_MAX = timestamp_t'(2**TS_W - 1);   // 4095

  typedef enum logic [1:0] {
    CMD_MATCH   = 2'd1,
    CMD_TRIGGER = 2'd2
  } record_cmd_t;

  typedef struct packed {
    record_cmd_t              cmd;     // 17:16
    trace_cfg_pkg::rule_vec_t rules;   // 15:12
    timestamp_t               ts;      // 11:0
  } record_word_t;

  typedef logic [CAP_LEN_W-1:0] cap_len_t;   // records per capture, 0 means 1

  typedef enum logic [1:0] {
    ST_IDLE      = 2'd0,
    ST_ARMED     = 2'd1,
    ST_CAPTURING = 2'd2
  } capture_state_t;

endpackage

`default_nettype wire

/* verilog/trace_cfg_pkg.sv */
// ==========================================================================
// Trace window and match rule definitions for the fe_clk front end.
// The newest trace byte always sits in bits 7:0 of the window.
// Rule 0 is the low slice of every per-rule array.
// ==========================================================================

`default_nettype none

package trace_cfg_pkg;

  localparam int WINDOW_BYTES = 4;   // window depth in bytes
  localparam int NUM_RULES    = 4;
  localparam int COUNT_W      = 8;   // per-rule count, saturating

  // one trace byte per fe_clk cycle
  typedef logic [7:0] trace_byte_t;

  // shift window, oldest byte at the top
  typedef logic [8*WINDOW_BYTES-1:0] window_t;

  typedef logic [NUM_RULES-1:0] rule_vec_t;   // one bit per rule

  // patterns and masks, one window-wide word per rule
  typedef window_t [NUM_RULES-1:0] rule_words_t;

  typedef logic [COUNT_W-1:0] match_count_t;
  typedef match_count_t [NUM_RULES-1:0] match_counts_t;

endpackage

`default_nettype wire
